//--- design/classifier_pkg.sv
package classifier_pkg;

    // Datapath sizes
    localparam int word_w         = 32;     // Stream and arithmetic word
    localparam int q_bits         = 8;      // Fractional bits, signed Q8
    localparam int input_feature  = 16;     // Feature vector length
    localparam int hidden_feature = 32;     // Hidden neurons
    localparam int output_feature = 3;      // Output scores

    // Index widths
    localparam int idx_w     = 6;                         // Row and column fields of a write
    localparam int in_idx_w  = $clog2(input_feature);     // Selects an input column
    localparam int hid_idx_w = $clog2(hidden_feature);    // Selects a hidden neuron
    localparam int out_idx_w = $clog2(output_feature);    // Selects an output score

    typedef logic signed [word_w-1:0] word_t;

    // One AXI4-Stream beat
    typedef struct packed {
        word_t data;
        logic  last;
    } axis_beat_t;

    // Where an accepted input word is stored
    typedef enum logic [2:0] {
        tgt_w1,
        tgt_b1,
        tgt_w2,
        tgt_b2,
        tgt_feature
    } load_target_t;

    // Write request from the controller into the engine storage
    typedef struct packed {
        logic             valid;
        load_target_t     target;
        logic [idx_w-1:0] row;    // Weight row, unused for biases and features
        logic [idx_w-1:0] col;    // Column or element index
        word_t            data;
    } param_wr_t;

    typedef word_t [output_feature-1:0] result_vec_t;

endpackage

//--- design/dot_product_tree.sv
module dot_product_tree #(
    parameter int n_inputs = classifier_pkg::input_feature
) (
    input  logic                                  S_AXIS_ACLK,
    input  logic                                  S_AXIS_ARESETN,
    input  logic                                  in_valid,
    input  classifier_pkg::word_t [n_inputs-1:0]  x,
    input  classifier_pkg::word_t [n_inputs-1:0]  w,
    output classifier_pkg::word_t                 sum,
    output logic                                  out_valid
);
    import classifier_pkg::*;

    localparam int levels = $clog2(n_inputs);   // Adder levels behind the multiply stage

    word_t       prod_lo [n_inputs];            // Low word of each raw product
    // Heap-ordered tree: node k sums nodes 2k and 2k+1, leaves start at n_inputs
    word_t       node [1:2*n_inputs-1];
    logic [levels:0] vld_sr;                    // Valid bit per pipeline stage

    // Signed multiply, only the low word is kept
    always_comb begin
        for (int i = 0; i < n_inputs; i++) begin
            prod_lo[i] = x[i] * w[i];
        end
    end

    // Every node is registered, so all leaves sit at the same depth and
    // the root is ready levels cycles after the products
    always_ff @(posedge S_AXIS_ACLK) begin
        for (int i = 0; i < n_inputs; i++) begin
            node[n_inputs + i] <= prod_lo[i] >>> q_bits;    // Rescale to Q8
        end
        for (int k = 1; k < n_inputs; k++) begin
            node[k] <= node[2*k] + node[2*k + 1];           // Wraps mod 2^32
        end
    end

    always_ff @(posedge S_AXIS_ACLK) begin
        if (!S_AXIS_ARESETN) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[levels-1:0], in_valid};
        end
    end

    assign sum       = node[1];
    assign out_valid = vld_sr[levels];     // 1 + log2(n_inputs) cycles after in_valid

endmodule

//--- design/mlp_engine.sv
module mlp_engine (
    input  logic                         S_AXIS_ACLK,
    input  logic                         S_AXIS_ARESETN,
    input  classifier_pkg::param_wr_t    param_wr,
    input  logic                         start,
    output logic                         done,
    output classifier_pkg::result_vec_t  results
);
    import classifier_pkg::*;

    typedef enum logic [1:0] {
        eng_idle,
        eng_l1,      // Hidden layer rows in flight
        eng_l2       // Output layer rows in flight
    } eng_state_t;

    // Parameter storage, one full weight row per entry
    word_t [input_feature-1:0]  w1_mem [hidden_feature];
    word_t                      b1_mem [hidden_feature];
    word_t [hidden_feature-1:0] w2_mem [output_feature];
    word_t                      b2_mem [output_feature];
    word_t [input_feature-1:0]  feat_vec;      // Current feature vector
    word_t [hidden_feature-1:0] hid_vec;       // Hidden layer after ReLU

    logic [hid_idx_w-1:0] wr_row;
    logic [hid_idx_w-1:0] wr_col;

    eng_state_t           state;
    logic                 issuing;              // Rows still to be fed to a tree
    logic [hid_idx_w-1:0] iss_cnt;              // Next row to issue
    logic [hid_idx_w-1:0] res_cnt;              // Next result to collect

    logic  t1_in_valid;
    logic  t1_out_valid;
    logic  t2_in_valid;
    logic  t2_out_valid;
    word_t t1_sum;
    word_t t2_sum;
    word_t hid_pre;                              // Hidden sum plus bias, before ReLU

    assign wr_row = param_wr.row[hid_idx_w-1:0];
    assign wr_col = param_wr.col[hid_idx_w-1:0];

    assign t1_in_valid = (state == eng_l1) && issuing;
    assign t2_in_valid = (state == eng_l2) && issuing;
    assign hid_pre     = t1_sum + b1_mem[res_cnt];

    // Layer 1: feature vector against one w1 row per cycle
    dot_product_tree #(
        .n_inputs (input_feature)
    ) u_tree_l1 (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .in_valid       (t1_in_valid),
        .x              (feat_vec),
        .w              (w1_mem[iss_cnt]),
        .sum            (t1_sum),
        .out_valid      (t1_out_valid)
    );

    // Layer 2: hidden vector against one w2 row per cycle
    dot_product_tree #(
        .n_inputs (hidden_feature)
    ) u_tree_l2 (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .in_valid       (t2_in_valid),
        .x              (hid_vec),
        .w              (w2_mem[iss_cnt[out_idx_w-1:0]]),
        .sum            (t2_sum),
        .out_valid      (t2_out_valid)
    );

    // Storage writes and layer results
    always_ff @(posedge S_AXIS_ACLK) begin
        if (param_wr.valid) begin
            case (param_wr.target)
                tgt_w1:      w1_mem[wr_row][wr_col[in_idx_w-1:0]]  <= param_wr.data;
                tgt_b1:      b1_mem[wr_col]                        <= param_wr.data;
                tgt_w2:      w2_mem[wr_row[out_idx_w-1:0]][wr_col] <= param_wr.data;
                tgt_b2:      b2_mem[wr_col[out_idx_w-1:0]]         <= param_wr.data;
                tgt_feature: feat_vec[wr_col[in_idx_w-1:0]]        <= param_wr.data;
                default: ;
            endcase
        end
        if (t1_out_valid) begin
            hid_vec[res_cnt] <= hid_pre[word_w-1] ? '0 : hid_pre;   // ReLU
        end
        if (t2_out_valid) begin
            results[res_cnt[out_idx_w-1:0]] <= t2_sum + b2_mem[res_cnt[out_idx_w-1:0]];
        end
    end

    // Layer sequencer; issue and collect counters run independently
    always_ff @(posedge S_AXIS_ACLK) begin
        if (!S_AXIS_ARESETN) begin
            state   <= eng_idle;
            issuing <= 1'b0;
            iss_cnt <= '0;
            res_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                eng_idle: begin
                    if (start) begin
                        state   <= eng_l1;
                        issuing <= 1'b1;
                        iss_cnt <= '0;
                        res_cnt <= '0;
                    end
                end
                eng_l1: begin
                    if (issuing) begin
                        iss_cnt <= iss_cnt + 1'b1;
                        if (iss_cnt == hid_idx_w'(hidden_feature - 1)) issuing <= 1'b0;
                    end
                    if (t1_out_valid) begin
                        res_cnt <= res_cnt + 1'b1;
                        // Last hidden value stored, hidden vector is complete
                        if (res_cnt == hid_idx_w'(hidden_feature - 1)) begin
                            state   <= eng_l2;
                            issuing <= 1'b1;
                            iss_cnt <= '0;
                            res_cnt <= '0;
                        end
                    end
                end
                eng_l2: begin
                    if (issuing) begin
                        iss_cnt <= iss_cnt + 1'b1;
                        if (iss_cnt == hid_idx_w'(output_feature - 1)) issuing <= 1'b0;
                    end
                    if (t2_out_valid) begin
                        res_cnt <= res_cnt + 1'b1;
                        if (res_cnt == hid_idx_w'(output_feature - 1)) begin
                            state <= eng_idle;
                            done  <= 1'b1;      // Same edge as the last score
                        end
                    end
                end
                default: state <= eng_idle;
            endcase
        end
    end

endmodule

//--- design/classifier_ctrl.sv
module classifier_ctrl (
    input  logic                         S_AXIS_ACLK,
    input  logic                         S_AXIS_ARESETN,
    input  classifier_pkg::axis_beat_t   s_beat,
    input  logic                         s_valid,
    output logic                         s_ready,
    output classifier_pkg::axis_beat_t   m_beat,
    output logic                         m_valid,
    input  logic                         m_ready,
    output classifier_pkg::param_wr_t    param_wr,
    output logic                         start,
    input  logic                         done,
    input  classifier_pkg::result_vec_t  results
);
    import classifier_pkg::*;

    typedef enum logic [2:0] {
        ph_w1,
        ph_b1,
        ph_w2,
        ph_b2,
        ph_feat,
        ph_comp,
        ph_wb
    } phase_t;

    phase_t               phase;
    logic [idx_w-1:0]     row_cnt;
    logic [idx_w-1:0]     col_cnt;
    logic [idx_w-1:0]     col_lim;        // Last column of a row in this phase
    load_target_t         cur_target;
    logic [out_idx_w-1:0] tx_cnt;         // Result word on the output stream
    logic                 rx;
    logic                 tx;
    logic                 start_pend;     // Last feature is on param_wr this cycle

    // Write request register, payload is captured per accepted beat
    logic                 wr_valid;
    load_target_t         wr_target;
    logic [idx_w-1:0]     wr_row;
    logic [idx_w-1:0]     wr_col;
    word_t                wr_data;

    assign rx = s_valid && s_ready;
    assign tx = m_valid && m_ready;

    assign s_ready = phase inside {ph_w1, ph_b1, ph_w2, ph_b2, ph_feat};
    assign m_valid = (phase == ph_wb);

    // Held while stalled, tx_cnt only moves on a transfer
    assign m_beat.data = results[tx_cnt];
    assign m_beat.last = (tx_cnt == out_idx_w'(output_feature - 1));

    assign param_wr = '{valid: wr_valid, target: wr_target, row: wr_row,
                        col: wr_col, data: wr_data};

    // Row length and destination of the current phase
    always_comb begin
        case (phase)
            ph_w1: begin
                col_lim    = idx_w'(input_feature - 1);
                cur_target = tgt_w1;
            end
            ph_b1: begin
                col_lim    = idx_w'(hidden_feature - 1);
                cur_target = tgt_b1;
            end
            ph_w2: begin
                col_lim    = idx_w'(hidden_feature - 1);
                cur_target = tgt_w2;
            end
            ph_b2: begin
                col_lim    = idx_w'(output_feature - 1);
                cur_target = tgt_b2;
            end
            default: begin
                col_lim    = idx_w'(input_feature - 1);
                cur_target = tgt_feature;
            end
        endcase
    end

    always_ff @(posedge S_AXIS_ACLK) begin
        if (rx) begin
            wr_target <= cur_target;
            wr_row    <= row_cnt;
            wr_col    <= col_cnt;
            wr_data   <= s_beat.data;
        end
    end

    always_ff @(posedge S_AXIS_ACLK) begin
        if (!S_AXIS_ARESETN) begin
            phase      <= ph_w1;
            row_cnt    <= '0;
            col_cnt    <= '0;
            tx_cnt     <= '0;
            wr_valid   <= 1'b0;
            start_pend <= 1'b0;
            start      <= 1'b0;
        end else begin
            wr_valid   <= rx;          // One request per accepted beat
            start_pend <= 1'b0;
            start      <= start_pend;  // Engine has the last feature by now
            if (rx) begin
                if (s_beat.last) begin
                    row_cnt <= '0;
                    col_cnt <= '0;
                    // TLAST closes the block
                    case (phase)
                        ph_w1:   phase <= ph_b1;
                        ph_b1:   phase <= ph_w2;
                        ph_w2:   phase <= ph_b2;
                        ph_b2:   phase <= ph_feat;
                        ph_feat: begin
                            phase      <= ph_comp;
                            start_pend <= 1'b1;
                        end
                        default: ;
                    endcase
                end else if (col_cnt == col_lim) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
            if (phase == ph_comp && done) begin
                phase <= ph_wb;
            end
            if (tx) begin
                if (m_beat.last) begin
                    tx_cnt <= '0;
                    phase  <= ph_feat;      // Weights stay, wait for next vector
                end else begin
                    tx_cnt <= tx_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- design/classifier_top.sv
module classifier_top (
    input  logic                   S_AXIS_ACLK,
    input  logic                   S_AXIS_ARESETN,
    // Input stream, parameters then feature vectors
    input  classifier_pkg::word_t  S_AXIS_TDATA,
    input  logic                   S_AXIS_TLAST,
    input  logic                   S_AXIS_TVALID,
    output logic                   S_AXIS_TREADY,
    // Output stream, one 3-word score packet per vector
    output classifier_pkg::word_t  M_AXIS_TDATA,
    output logic                   M_AXIS_TLAST,
    output logic                   M_AXIS_TVALID,
    input  logic                   M_AXIS_TREADY
);
    import classifier_pkg::*;

    axis_beat_t  s_beat;
    axis_beat_t  m_beat;
    param_wr_t   param_wr;
    logic        start;
    logic        done;
    result_vec_t results;

    assign s_beat       = '{data: S_AXIS_TDATA, last: S_AXIS_TLAST};
    assign M_AXIS_TDATA = m_beat.data;
    assign M_AXIS_TLAST = m_beat.last;

    classifier_ctrl u_ctrl (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .s_beat         (s_beat),
        .s_valid        (S_AXIS_TVALID),
        .s_ready        (S_AXIS_TREADY),
        .m_beat         (m_beat),
        .m_valid        (M_AXIS_TVALID),
        .m_ready        (M_AXIS_TREADY),
        .param_wr       (param_wr),
        .start          (start),
        .done           (done),
        .results        (results)
    );

    mlp_engine u_engine (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .param_wr       (param_wr),
        .start          (start),
        .done           (done),
        .results        (results)
    );

endmodule

//--- tb/classifier_properties.sv
module classifier_properties (
    input logic                       S_AXIS_ACLK,
    input logic                       S_AXIS_ARESETN,
    input logic                       s_ready,
    input logic                       m_valid,
    input logic                       m_ready,
    input classifier_pkg::axis_beat_t m_beat
);
    int reset_fails   = 0;    // Failures per assertion, summed by the testbench
    int hold_fails    = 0;
    int overlap_fails = 0;

    // Output idle right out of reset
    reset_idle: assert property (@(posedge S_AXIS_ACLK) !S_AXIS_ARESETN |=> !m_valid)
        else begin
            reset_fails++;
            $error("m_valid high after reset");
        end

    // Stalled beat keeps its data and last flag
    beat_hold: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        m_valid && !m_ready |=> m_valid && $stable(m_beat))
        else begin
            hold_fails++;
            $error("m_beat changed while stalled");
        end

    // Input closed for the whole write-back
    no_overlap: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        !(s_ready && m_valid))
        else begin
            overlap_fails++;
            $error("s_ready and m_valid high together");
        end

endmodule

bind classifier_ctrl classifier_properties u_props (
    .S_AXIS_ACLK    (S_AXIS_ACLK),
    .S_AXIS_ARESETN (S_AXIS_ARESETN),
    .s_ready        (s_ready),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .m_beat         (m_beat)
);

//--- tb/classifier_checker.sv
module classifier_checker (
    input  logic                  S_AXIS_ACLK,
    input  logic                  S_AXIS_ARESETN,
    input  classifier_pkg::word_t s_tdata,
    input  logic                  s_tlast,
    input  logic                  s_tvalid,
    input  logic                  s_tready,
    input  classifier_pkg::word_t m_tdata,
    input  logic                  m_tlast,
    input  logic                  m_tvalid,
    input  logic                  m_tready,
    output int                    packets,     // Output packets completed
    output int                    checks,
    output int                    errors
);
    import classifier_pkg::*;

    // Copy of the parameters as seen on the input stream
    word_t w1 [hidden_feature][input_feature];
    word_t b1 [hidden_feature];
    word_t w2 [output_feature][hidden_feature];
    word_t b2 [output_feature];
    word_t feat [input_feature];
    word_t exp_q [$];        // Expected scores in output order
    int    blk;              // 0 w1, 1 b1, 2 w2, 3 b2, then features
    int    idx;              // Word within the block
    int    beat;             // Output beat within the packet
    int    err_mark;         // Error count when the packet began
    logic  busy;             // Vector taken, packet not finished
    logic  reset_seen;
    logic  stalled;          // Last edge saw valid without ready
    word_t held_data;
    logic  held_last;

    // Q8 product: low word of the full signed product, then rescaled
    function automatic word_t qmul(word_t a, word_t b);
        logic signed [63:0] full;
        full = 64'(a) * 64'(b);
        return word_t'(full[31:0]) >>> q_bits;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Both layers on the current feature vector
    task automatic predict();
        word_t hid [hidden_feature];
        word_t acc;
        for (int h = 0; h < hidden_feature; h++) begin
            acc = b1[h];
            for (int i = 0; i < input_feature; i++) begin
                acc = acc + qmul(feat[i], w1[h][i]);    // Wraps mod 2^32
            end
            hid[h] = (acc < 0) ? word_t'(0) : acc;     // ReLU
        end
        for (int o = 0; o < output_feature; o++) begin
            acc = b2[o];
            for (int h = 0; h < hidden_feature; h++) begin
                acc = acc + qmul(hid[h], w2[o][h]);
            end
            exp_q.push_back(acc);
        end
    endtask

    always @(posedge S_AXIS_ACLK) begin
        if (!S_AXIS_ARESETN) begin
            packets = 0;
            checks = 0;
            errors = 0;
            blk = 0;
            idx = 0;
            beat = 0;
            err_mark = 0;
            busy = 1'b0;
            reset_seen = 1'b0;
            stalled = 1'b0;
            exp_q.delete();
        end else begin
            if (!reset_seen) begin             // First edge out of reset
                reset_seen = 1'b1;
                compare("M_AXIS_TVALID", 32'(m_tvalid), 32'd0);
                compare("S_AXIS_TREADY", 32'(s_tready), 32'd1);
            end
            // Input side, sorted into blocks by TLAST
            if (s_tvalid && s_tready) begin
                if (busy) begin
                    errors++;
                    $display("input beat accepted while a result was still pending");
                end
                case (blk)
                    0: w1[idx / input_feature][idx % input_feature] = s_tdata;
                    1: b1[idx] = s_tdata;
                    2: w2[idx / hidden_feature][idx % hidden_feature] = s_tdata;
                    3: b2[idx] = s_tdata;
                    default: feat[idx] = s_tdata;
                endcase
                idx++;
                if (s_tlast) begin
                    if (blk >= 4) begin
                        predict();
                        busy = 1'b1;
                    end else begin
                        blk++;
                    end
                    idx = 0;
                end
            end
            // A stalled beat must still be there, unchanged
            if (stalled) begin
                checks++;
                if (!m_tvalid || m_tdata !== held_data || m_tlast !== held_last) begin
                    errors++;
                    $display("output beat changed or was withdrawn while stalled");
                end
            end
            stalled   = m_tvalid && !m_tready;
            held_data = m_tdata;
            held_last = m_tlast;
            if (m_tvalid && m_tready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("output beat arrived with no result pending");
                end else begin
                    compare("M_AXIS_TDATA", m_tdata, exp_q.pop_front());
                    compare("M_AXIS_TLAST", 32'(m_tlast), 32'(beat == output_feature - 1));
                    beat++;
                    if (beat == output_feature) begin   // Packet complete
                        $display("vector %0d: %0d beats, %0d errors",
                                 packets, beat, errors - err_mark);
                        packets++;
                        beat = 0;
                        err_mark = errors;
                        busy = 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- tb/classifier_tb.sv
module classifier_tb;
    import classifier_pkg::*;

    localparam int n_cases      = 6;
    localparam int beat_limit   = 50;     // Cycles one input beat may wait
    localparam int packet_limit = 400;    // Cycles from last feature to packet end

    // One table row
    typedef struct packed {
        logic       zero_feat;    // All-zero features
        logic       junk;         // Junk beats offered during compute
        logic [7:0] ready_pat;    // M_AXIS_TREADY per cycle, LSB first, rotating
    } vec_case_t;

    logic      S_AXIS_ACLK;
    logic      S_AXIS_ARESETN;
    word_t     S_AXIS_TDATA;
    logic      S_AXIS_TLAST;
    logic      S_AXIS_TVALID;
    logic      S_AXIS_TREADY;
    word_t     M_AXIS_TDATA;
    logic      M_AXIS_TLAST;
    logic      M_AXIS_TVALID;
    logic      M_AXIS_TREADY;

    int        packets;
    int        checks;
    int        errors;
    int        assert_fails;
    logic      timeout_hit;
    logic [31:0] rng_state;
    vec_case_t cases [n_cases];

    classifier_top DUT (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .S_AXIS_TDATA   (S_AXIS_TDATA),
        .S_AXIS_TLAST   (S_AXIS_TLAST),
        .S_AXIS_TVALID  (S_AXIS_TVALID),
        .S_AXIS_TREADY  (S_AXIS_TREADY),
        .M_AXIS_TDATA   (M_AXIS_TDATA),
        .M_AXIS_TLAST   (M_AXIS_TLAST),
        .M_AXIS_TVALID  (M_AXIS_TVALID),
        .M_AXIS_TREADY  (M_AXIS_TREADY)
    );

    classifier_checker u_checker (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .s_tdata        (S_AXIS_TDATA),
        .s_tlast        (S_AXIS_TLAST),
        .s_tvalid       (S_AXIS_TVALID),
        .s_tready       (S_AXIS_TREADY),
        .m_tdata        (M_AXIS_TDATA),
        .m_tlast        (M_AXIS_TLAST),
        .m_tvalid       (M_AXIS_TVALID),
        .m_tready       (M_AXIS_TREADY),
        .packets        (packets),
        .checks         (checks),
        .errors         (errors)
    );

    always #5 S_AXIS_ACLK = ~S_AXIS_ACLK;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // -512..511, that is -2.0 to just under 2.0 in Q8
    function automatic word_t rand_small();
        rng_state = xorshift(rng_state);
        return word_t'(rng_state[9:0]) - 512;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_beat(input word_t data, input logic last);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        S_AXIS_TDATA  = data;
        S_AXIS_TLAST  = last;
        S_AXIS_TVALID = 1'b1;
        while (!taken && !timeout_hit) begin
            taken = S_AXIS_TREADY;      // Stable until the next rising edge
            @(negedge S_AXIS_ACLK);
            waited++;
            if (!taken && waited > beat_limit) begin
                $display("timeout: input beat not accepted within %0d cycles", beat_limit);
                timeout_hit = 1'b1;
            end
        end
    endtask

    task automatic send_random_block(input int len);
        for (int i = 0; i < len; i++) begin
            send_beat(rand_small(), i == len - 1);    // TLAST closes the block
        end
    endtask

    // One feature vector, then wait for its packet under the row's ready pattern
    task automatic run_case(input vec_case_t c);
        int         target;
        int         k;
        logic [7:0] pat;
        target = packets + 1;
        k      = 0;
        pat    = c.ready_pat;
        for (int i = 0; i < input_feature; i++) begin
            send_beat(c.zero_feat ? word_t'(0) : rand_small(), i == input_feature - 1);
        end
        S_AXIS_TVALID = c.junk && !timeout_hit;
        while (packets < target && !timeout_hit) begin
            if (M_AXIS_TVALID) begin
                S_AXIS_TVALID = 1'b0;   // Junk only while computing
            end
            if (S_AXIS_TVALID) begin
                S_AXIS_TDATA = rand_small();
                S_AXIS_TLAST = rng_state[0];
            end
            M_AXIS_TREADY = pat[0];
            pat = {pat[0], pat[7:1]};
            @(negedge S_AXIS_ACLK);
            k++;
            if (packets < target && k > packet_limit) begin
                $display("timeout: output packet incomplete after %0d cycles", packet_limit);
                timeout_hit = 1'b1;
            end
        end
        S_AXIS_TVALID = 1'b0;
        M_AXIS_TREADY = 1'b1;
    endtask

    initial begin
        S_AXIS_ACLK    = 1'b0;
        S_AXIS_ARESETN = 1'b0;
        S_AXIS_TDATA   = '0;
        S_AXIS_TLAST   = 1'b0;
        S_AXIS_TVALID  = 1'b0;
        M_AXIS_TREADY  = 1'b1;
        timeout_hit    = 1'b0;
        rng_state      = 32'd7848;
        cases[0] = '{zero_feat: 1'b0, junk: 1'b0, ready_pat: 8'hff};
        cases[1] = '{zero_feat: 1'b0, junk: 1'b0, ready_pat: 8'hff};
        cases[2] = '{zero_feat: 1'b1, junk: 1'b0, ready_pat: 8'hff};   // Bias only
        cases[3] = '{zero_feat: 1'b0, junk: 1'b0, ready_pat: 8'b0110_0010};
        cases[4] = '{zero_feat: 1'b0, junk: 1'b1, ready_pat: 8'hff};
        cases[5] = '{zero_feat: 1'b0, junk: 1'b1, ready_pat: 8'b0100_1000};

        repeat (10) @(posedge S_AXIS_ACLK);
        @(negedge S_AXIS_ACLK);
        S_AXIS_ARESETN = 1'b1;
        @(negedge S_AXIS_ACLK);             // Reset state checked on this edge

        send_random_block(hidden_feature * input_feature);     // w1
        send_random_block(hidden_feature);                     // b1
        send_random_block(output_feature * hidden_feature);    // w2
        send_random_block(output_feature);                     // b2
        S_AXIS_TVALID = 1'b0;

        for (int i = 0; i < n_cases; i++) begin
            if (!timeout_hit) begin
                run_case(cases[i]);
            end
        end
        repeat (5) @(negedge S_AXIS_ACLK);

        assert_fails = DUT.u_ctrl.u_props.reset_fails + DUT.u_ctrl.u_props.hold_fails
                     + DUT.u_ctrl.u_props.overlap_fails;
        $display("vectors %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
                 packets, n_cases, checks, errors, assert_fails);
        if (timeout_hit || errors != 0 || assert_fails != 0 || packets != n_cases) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/classifier_pkg.sv
design/dot_product_tree.sv
design/mlp_engine.sv
design/classifier_ctrl.sv
design/classifier_top.sv
tb/classifier_properties.sv
tb/classifier_checker.sv
tb/classifier_tb.sv

//--- Makefile
# Verilator flow for the classifier testbench

TOP := classifier_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) \
		--Mdir obj_dir -o classifier_sim
	./obj_dir/classifier_sim +verilator+error+limit+100 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "simulation ended without a result line"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
